// File: hw/cdp_rdma_pkg.sv
// shared widths, payload layout and layer state for the read DMA ingress
// atom size is fixed at 32 bytes; width groups hold at most 8 atoms
`default_nettype none

package cdp_rdma_pkg;

  // ==========================================================================
  // memory atom and cube geometry
  // ==========================================================================
  localparam int atom_bytes    = 32;
  localparam int atom_shift    = 5;
  localparam int w_group_atoms = 8;
  // channel, width, height register fields
  localparam int dim_w         = 13;

  // address, strides, request payload
  localparam int addr_w        = 64;
  localparam int stride_w      = 32;
  // only the low 3 bits of the size field carry information
  localparam int size_w        = 15;
  localparam int dma_req_pd_w  = addr_w + size_w;

  // context-queue entry layout
  localparam int cq_pd_w       = 7;
  localparam int cq_size_lsb   = 0;
  localparam int cq_align_bit  = 3;
  localparam int cq_last_w_bit = 4;
  localparam int cq_last_h_bit = 5;
  localparam int cq_last_c_bit = 6;

  // stall counter and perf registers
  localparam int perf_w        = 32;

  typedef enum logic [1:0] {
    layer_idle,
    layer_fetch,
    layer_drain
  } layer_state_e;

endpackage

`default_nettype wire

// File: hw/rdma_layer_ctrl.sv
// layer FSM: idle, fetch, drain; drain holds until egress reports done
// each valid is gated by the other side's ready so both accept together
`timescale 1ns/1ps
`default_nettype none

module rdma_layer_ctrl (
  input  logic nvdla_core_clk,
  input  logic nvdla_core_rstn,
  input  logic op_en,
  input  logic eg2ig_done,
  input  logic dma_ready,
  input  logic cq_ready,
  input  logic cube_end,
  output logic dma_valid,
  output logic cq_valid,
  output logic cmd_accept,
  output logic op_load,
  output logic layer_end
);

  cdp_rdma_pkg::layer_state_e state;
  logic                       fetching;

  assign fetching   = (state == cdp_rdma_pkg::layer_fetch);
  // start pulse, one cycle since the state leaves idle on the next edge
  assign op_load    = (state == cdp_rdma_pkg::layer_idle) & op_en;

  // cross-gated valids
  assign dma_valid  = fetching & cq_ready;
  assign cq_valid   = fetching & dma_ready;
  assign cmd_accept = fetching & dma_ready & cq_ready;
  // accept of the final step of the cube
  assign layer_end  = cmd_accept & cube_end;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= cdp_rdma_pkg::layer_idle;
    end else begin
      case (state)
        cdp_rdma_pkg::layer_idle: begin
          if (op_load) state <= cdp_rdma_pkg::layer_fetch;
        end
        cdp_rdma_pkg::layer_fetch: begin
          if (layer_end) state <= cdp_rdma_pkg::layer_drain;
        end
        cdp_rdma_pkg::layer_drain: begin
          // next layer config may only load after egress is done
          if (eg2ig_done) state <= cdp_rdma_pkg::layer_idle;
        end
        default: state <= cdp_rdma_pkg::layer_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/rdma_cube_walker.sv
// walks the cube: channel groups innermost, width groups, then lines
// channel, width, height are value minus one; counters wrap at cube end
`timescale 1ns/1ps
`default_nettype none

module rdma_cube_walker (
  input  logic                           nvdla_core_clk,
  input  logic                           nvdla_core_rstn,
  input  logic                           cmd_accept,
  input  logic [cdp_rdma_pkg::dim_w-1:0] channel,
  input  logic [cdp_rdma_pkg::dim_w-1:0] width,
  input  logic [cdp_rdma_pkg::dim_w-1:0] height,
  output logic                           is_last_c,
  output logic                           is_last_w,
  output logic                           is_last_h,
  output logic                           cube_end,
  output logic [2:0]                     req_size
);

  logic [cdp_rdma_pkg::dim_w-cdp_rdma_pkg::atom_shift-1:0] c_cnt;
  logic [cdp_rdma_pkg::dim_w:0]                            w_cnt;
  logic [cdp_rdma_pkg::dim_w-1:0]                          h_cnt;
  logic [cdp_rdma_pkg::dim_w:0]                            w_sum;
  logic [cdp_rdma_pkg::dim_w:0]                            w_groups;
  logic                                                    slice_end;

  // ==========================================================================
  // width group count: ceil((width + 1) / 8)
  // ==========================================================================
  // width + 8 equals (width + 1) + 7
  assign w_sum    = {1'b0, width}
                  + (cdp_rdma_pkg::dim_w + 1)'(cdp_rdma_pkg::w_group_atoms);
  assign w_groups = w_sum >> $clog2(cdp_rdma_pkg::w_group_atoms);

  // position flags
  assign is_last_c  = (c_cnt == channel[cdp_rdma_pkg::dim_w-1:cdp_rdma_pkg::atom_shift]);
  assign is_last_w  = (w_cnt == w_groups - (cdp_rdma_pkg::dim_w + 1)'(1));
  assign is_last_h  = (h_cnt == height);
  assign slice_end  = is_last_c & is_last_w;
  assign cube_end   = slice_end & is_last_h;

  // ==========================================================================
  // counters, all step on accept only
  // ==========================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      c_cnt <= '0;
      w_cnt <= '0;
      h_cnt <= '0;
    end else if (cmd_accept) begin
      // channel group
      if (is_last_c) c_cnt <= '0;
      else c_cnt <= c_cnt + 1'b1;
      // width group moves after a full channel walk
      if (slice_end) w_cnt <= '0;
      else if (is_last_c) w_cnt <= w_cnt + 1'b1;
      // next line after a full slice
      if (cube_end) h_cnt <= '0;
      else if (slice_end) h_cnt <= h_cnt + 1'b1;
    end
  end

  // ==========================================================================
  // atoms in this request, minus one
  // ==========================================================================
  // a lone group is its own tail group
  always_comb begin
    if (is_last_w) begin
      // partial tail group
      req_size = width[2:0];
    end else begin
      req_size = 3'd7;
    end
  end

endmodule

`default_nettype wire

// File: hw/rdma_addr_gen.sv
// request address generation; strides are added unsigned, no wrap check
// all bases load from the source base at layer start
`timescale 1ns/1ps
`default_nettype none

module rdma_addr_gen (
  input  logic                              nvdla_core_clk,
  input  logic                              nvdla_core_rstn,
  input  logic                              op_load,
  input  logic                              cmd_accept,
  input  logic                              is_last_c,
  input  logic                              is_last_w,
  input  logic [2:0]                        req_size,
  input  logic [cdp_rdma_pkg::addr_w-1:0]   base_addr,
  input  logic [cdp_rdma_pkg::stride_w-1:0] line_stride,
  input  logic [cdp_rdma_pkg::stride_w-1:0] surf_stride,
  output logic [cdp_rdma_pkg::addr_w-1:0]   req_addr
);

  logic [cdp_rdma_pkg::addr_w-1:0] line_base;
  logic [cdp_rdma_pkg::addr_w-1:0] grp_base;
  logic [cdp_rdma_pkg::addr_w-1:0] grp_step;
  logic [cdp_rdma_pkg::addr_w-1:0] next_line;

  // bytes covered by the current width group
  assign grp_step  = (cdp_rdma_pkg::addr_w'(req_size) + cdp_rdma_pkg::addr_w'(1))
                   * cdp_rdma_pkg::addr_w'(cdp_rdma_pkg::atom_bytes);
  assign next_line = line_base + cdp_rdma_pkg::addr_w'(line_stride);

  // ==========================================================================
  // line base, group base, current address
  // ==========================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      line_base <= '0;
      grp_base  <= '0;
      req_addr  <= '0;
    end else if (op_load) begin
      line_base <= base_addr;
      grp_base  <= base_addr;
      req_addr  <= base_addr;
    end else if (cmd_accept) begin
      if (!is_last_c) begin
        // next channel group, same width group
        req_addr <= req_addr + cdp_rdma_pkg::addr_w'(surf_stride);
      end else if (!is_last_w) begin
        // channels done, step to next width group
        grp_base <= grp_base + grp_step;
        req_addr <= grp_base + grp_step;
      end else begin
        // slice done, everything restarts one line down
        line_base <= next_line;
        grp_base  <= next_line;
        req_addr  <= next_line;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/rdma_stall_perf.sv
// read stall counter, reported per layer into alternating perf registers
// count clears at each layer end; no saturation at the top
`timescale 1ns/1ps
`default_nettype none

module rdma_stall_perf (
  input  logic                            nvdla_core_clk,
  input  logic                            nvdla_core_rstn,
  input  logic                            dma_en,
  input  logic                            dma_valid,
  input  logic                            dma_ready,
  input  logic                            layer_end,
  output logic [cdp_rdma_pkg::perf_w-1:0] perf_d0,
  output logic [cdp_rdma_pkg::perf_w-1:0] perf_d1
);

  logic [cdp_rdma_pkg::perf_w-1:0] stall_cnt;
  logic                            layer_flag;
  logic                            stall;

  // request presented but not taken
  assign stall = dma_en & dma_valid & ~dma_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt  <= '0;
      layer_flag <= 1'b0;
      perf_d0    <= '0;
      perf_d1    <= '0;
    end else begin
      if (layer_end) begin
        // even layers go to d0, odd ones to d1
        if (layer_flag) perf_d1 <= stall_cnt;
        else perf_d0 <= stall_cnt;
        layer_flag <= ~layer_flag;
        stall_cnt  <= '0;
      end else if (stall) begin
        stall_cnt <= stall_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/cdp_rdma_ig.sv
// read DMA ingress for the pooling engine, single memory request port
// register inputs must stay stable while a layer is running
// request and queue entry are accepted together, never one alone
`timescale 1ns/1ps
`default_nettype none

module cdp_rdma_ig (
  input  logic                                   nvdla_core_clk,
  input  logic                                   nvdla_core_rstn,
  // register file
  input  logic                                   reg2dp_op_en,
  input  logic                                   reg2dp_dma_en,
  input  logic [cdp_rdma_pkg::dim_w-1:0]         reg2dp_channel,
  input  logic [cdp_rdma_pkg::dim_w-1:0]         reg2dp_width,
  input  logic [cdp_rdma_pkg::dim_w-1:0]         reg2dp_height,
  input  logic [31:0]                            reg2dp_src_base_addr_high,
  input  logic [31:0]                            reg2dp_src_base_addr_low,
  input  logic [cdp_rdma_pkg::stride_w-1:0]      reg2dp_src_line_stride,
  input  logic [cdp_rdma_pkg::stride_w-1:0]      reg2dp_src_surface_stride,
  // memory read request
  output logic                                   dma_rd_req_valid,
  input  logic                                   dma_rd_req_ready,
  output logic [cdp_rdma_pkg::dma_req_pd_w-1:0]  dma_rd_req_pd,
  // context queue towards egress
  output logic                                   cq_wr_valid,
  input  logic                                   cq_wr_ready,
  output logic [cdp_rdma_pkg::cq_pd_w-1:0]       cq_wr_pd,
  // egress side finished the layer
  input  logic                                   eg2ig_done,
  // ping-pong stall counts
  output logic [cdp_rdma_pkg::perf_w-1:0]        dp2reg_d0_perf_read_stall,
  output logic [cdp_rdma_pkg::perf_w-1:0]        dp2reg_d1_perf_read_stall
);

  logic                              op_load;
  logic                              cmd_accept;
  logic                              layer_end;
  logic                              is_last_c;
  logic                              is_last_w;
  logic                              is_last_h;
  logic                              cube_end;
  logic [2:0]                        req_size;
  logic [cdp_rdma_pkg::addr_w-1:0]   base_addr;
  logic [cdp_rdma_pkg::addr_w-1:0]   req_addr;

  // ==========================================================================
  // layer sequencing and joined handshake
  // ==========================================================================
  rdma_layer_ctrl u_layer_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (reg2dp_op_en),
    .eg2ig_done      (eg2ig_done),
    .dma_ready       (dma_rd_req_ready),
    .cq_ready        (cq_wr_ready),
    .cube_end        (cube_end),
    .dma_valid       (dma_rd_req_valid),
    .cq_valid        (cq_wr_valid),
    .cmd_accept      (cmd_accept),
    .op_load         (op_load),
    .layer_end       (layer_end)
  );

  // position in the cube, size of current request
  rdma_cube_walker u_cube_walker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cmd_accept      (cmd_accept),
    .channel         (reg2dp_channel),
    .width           (reg2dp_width),
    .height          (reg2dp_height),
    .is_last_c       (is_last_c),
    .is_last_w       (is_last_w),
    .is_last_h       (is_last_h),
    .cube_end        (cube_end),
    .req_size        (req_size)
  );

  // 64-bit source base from the two register halves
  assign base_addr = {reg2dp_src_base_addr_high, reg2dp_src_base_addr_low};

  rdma_addr_gen u_addr_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cmd_accept      (cmd_accept),
    .is_last_c       (is_last_c),
    .is_last_w       (is_last_w),
    .req_size        (req_size),
    .base_addr       (base_addr),
    .line_stride     (reg2dp_src_line_stride),
    .surf_stride     (reg2dp_src_surface_stride),
    .req_addr        (req_addr)
  );

  // stall cycles seen on the request port
  rdma_stall_perf u_stall_perf (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .dma_en          (reg2dp_dma_en),
    .dma_valid       (dma_rd_req_valid),
    .dma_ready       (dma_rd_req_ready),
    .layer_end       (layer_end),
    .perf_d0         (dp2reg_d0_perf_read_stall),
    .perf_d1         (dp2reg_d1_perf_read_stall)
  );

  // ==========================================================================
  // payload packing
  // ==========================================================================
  // request: address low, zero-extended size above
  assign dma_rd_req_pd = {{(cdp_rdma_pkg::size_w - 3){1'b0}}, req_size, req_addr};

  // queue entry: size, align (always low), last flags
  assign cq_wr_pd[cdp_rdma_pkg::cq_size_lsb +: 3]     = req_size;
  assign cq_wr_pd[cdp_rdma_pkg::cq_align_bit]         = 1'b0;
  assign cq_wr_pd[cdp_rdma_pkg::cq_last_w_bit]        = is_last_w;
  assign cq_wr_pd[cdp_rdma_pkg::cq_last_h_bit]        = is_last_h;
  assign cq_wr_pd[cdp_rdma_pkg::cq_last_c_bit]        = is_last_c;

endmodule

`default_nettype wire

// File: sim/tb_cdp_rdma_ig.sv
// directed testbench for the read DMA ingress
// register inputs change only between layers; readies are random in some tests
// stall counts are tracked here and checked against the ping-pong perf registers
`timescale 1ns/1ps
`default_nettype none

module tb_cdp_rdma_ig;

  logic                                  nvdla_core_clk;
  logic                                  nvdla_core_rstn;
  logic                                  reg2dp_op_en;
  logic                                  reg2dp_dma_en;
  logic [cdp_rdma_pkg::dim_w-1:0]        reg2dp_channel;
  logic [cdp_rdma_pkg::dim_w-1:0]        reg2dp_width;
  logic [cdp_rdma_pkg::dim_w-1:0]        reg2dp_height;
  logic [31:0]                           reg2dp_src_base_addr_high;
  logic [31:0]                           reg2dp_src_base_addr_low;
  logic [cdp_rdma_pkg::stride_w-1:0]     reg2dp_src_line_stride;
  logic [cdp_rdma_pkg::stride_w-1:0]     reg2dp_src_surface_stride;
  logic                                  dma_rd_req_valid;
  logic                                  dma_rd_req_ready;
  logic [cdp_rdma_pkg::dma_req_pd_w-1:0] dma_rd_req_pd;
  logic                                  cq_wr_valid;
  logic                                  cq_wr_ready;
  logic [cdp_rdma_pkg::cq_pd_w-1:0]      cq_wr_pd;
  logic                                  eg2ig_done;
  logic [cdp_rdma_pkg::perf_w-1:0]       dp2reg_d0_perf_read_stall;
  logic [cdp_rdma_pkg::perf_w-1:0]       dp2reg_d1_perf_read_stall;

  // expected walk, one entry per accepted step
  logic [cdp_rdma_pkg::addr_w-1:0]       exp_addr[$];
  logic [2:0]                            exp_size[$];
  // {last_c, last_h, last_w}, same order as queue bits 6..4
  logic [2:0]                            exp_flags[$];
  logic [cdp_rdma_pkg::perf_w-1:0]       perf_seen[2];
  logic [31:0]                           rng_state;
  int                                    layer_cnt;

  cdp_rdma_ig dut_i (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #2 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ==========================================================================
  // helpers
  // ==========================================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_addr(input string name, input logic [cdp_rdma_pkg::addr_w-1:0] exp,
                            input logic [cdp_rdma_pkg::addr_w-1:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: address expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_size(input string name, input logic [cdp_rdma_pkg::size_w-1:0] exp,
                            input logic [cdp_rdma_pkg::size_w-1:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: size expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // last flags plus the align bit, which is always low
  task automatic check_flags(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: last flags c/h/w and align expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_perf(input string name, input logic [cdp_rdma_pkg::perf_w-1:0] exp,
                            input logic [cdp_rdma_pkg::perf_w-1:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: stall perf expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // reference walk: channel groups inside width groups inside lines
  task automatic build_model(input logic [cdp_rdma_pkg::dim_w-1:0] c,
                             input logic [cdp_rdma_pkg::dim_w-1:0] w,
                             input logic [cdp_rdma_pkg::dim_w-1:0] h,
                             input logic [cdp_rdma_pkg::addr_w-1:0] base,
                             input logic [cdp_rdma_pkg::stride_w-1:0] lstr,
                             input logic [cdp_rdma_pkg::stride_w-1:0] sstr);
    int atoms;
    int groups;
    int cgroups;
    int hh;
    int g;
    int k;
    logic [cdp_rdma_pkg::addr_w-1:0] line;
    logic [cdp_rdma_pkg::addr_w-1:0] grp;
    logic [2:0] sz;
    exp_addr.delete();
    exp_size.delete();
    exp_flags.delete();
    // fields hold value minus one
    atoms = int'(w) + 1;
    // partial groups round up
    groups = (atoms + cdp_rdma_pkg::w_group_atoms - 1) / cdp_rdma_pkg::w_group_atoms;
    cgroups = int'(c) / cdp_rdma_pkg::atom_bytes + 1;
    for (hh = 0; hh <= int'(h); hh++) begin
      line = base + cdp_rdma_pkg::addr_w'(hh) * cdp_rdma_pkg::addr_w'(lstr);
      grp = line;
      for (g = 0; g < groups; g++) begin
        // only the tail group can be partial
        if (g == groups - 1) sz = w[2:0];
        else sz = 3'd7;
        for (k = 0; k < cgroups; k++) begin
          exp_addr.push_back(grp + cdp_rdma_pkg::addr_w'(k) * cdp_rdma_pkg::addr_w'(sstr));
          exp_size.push_back(sz);
          exp_flags.push_back({k == cgroups - 1, hh == int'(h), g == groups - 1});
        end
        grp = grp + (cdp_rdma_pkg::addr_w'(sz) + 1) * cdp_rdma_pkg::atom_bytes;
      end
    end
  endtask

  // one full layer: start, walk with checks, drain, done pulse, perf check
  task automatic run_layer(input string name,
                           input logic [cdp_rdma_pkg::dim_w-1:0] c,
                           input logic [cdp_rdma_pkg::dim_w-1:0] w,
                           input logic [cdp_rdma_pkg::dim_w-1:0] h,
                           input logic [cdp_rdma_pkg::addr_w-1:0] base,
                           input logic [cdp_rdma_pkg::stride_w-1:0] lstr,
                           input logic [cdp_rdma_pkg::stride_w-1:0] sstr,
                           input logic rand_rdy,
                           input logic dma_en);
    int idx;
    int total;
    int cycles;
    int stalls;
    int dma_xfers;
    int cq_xfers;
    build_model(c, w, h, base, lstr, sstr);
    total = exp_addr.size();
    idx = 0;
    cycles = 0;
    stalls = 0;
    dma_xfers = 0;
    cq_xfers = 0;
    @(posedge nvdla_core_clk);
    reg2dp_channel <= c;
    reg2dp_width <= w;
    reg2dp_height <= h;
    reg2dp_src_base_addr_high <= base[63:32];
    reg2dp_src_base_addr_low <= base[31:0];
    reg2dp_src_line_stride <= lstr;
    reg2dp_src_surface_stride <= sstr;
    reg2dp_dma_en <= dma_en;
    reg2dp_op_en <= 1'b1;
    while (idx < total) begin
      @(posedge nvdla_core_clk);
      reg2dp_op_en <= 1'b0;
      if (rand_rdy) begin
        rng_state = xorshift32(rng_state);
        dma_rd_req_ready <= rng_state[3];
        cq_wr_ready <= rng_state[11];
      end else begin
        dma_rd_req_ready <= 1'b1;
        cq_wr_ready <= 1'b1;
      end
      @(negedge nvdla_core_clk);
      // a presented payload must already be the next expected step
      if (dma_rd_req_valid) begin
        check_addr(name, exp_addr[idx], dma_rd_req_pd[cdp_rdma_pkg::addr_w-1:0]);
        check_size(name, cdp_rdma_pkg::size_w'(exp_size[idx]),
                   dma_rd_req_pd[cdp_rdma_pkg::addr_w +: cdp_rdma_pkg::size_w]);
        if (!dma_rd_req_ready && dma_en) stalls++;
      end
      if (cq_wr_valid) begin
        check_size(name, cdp_rdma_pkg::size_w'(exp_size[idx]),
                   cdp_rdma_pkg::size_w'(cq_wr_pd[cdp_rdma_pkg::cq_size_lsb +: 3]));
        check_flags(name, {exp_flags[idx], 1'b0}, {cq_wr_pd[cdp_rdma_pkg::cq_last_c_bit],
                                                   cq_wr_pd[cdp_rdma_pkg::cq_last_h_bit],
                                                   cq_wr_pd[cdp_rdma_pkg::cq_last_w_bit],
                                                   cq_wr_pd[cdp_rdma_pkg::cq_align_bit]});
      end
      if (dma_rd_req_valid && dma_rd_req_ready) dma_xfers++;
      if (cq_wr_valid && cq_wr_ready) cq_xfers++;
      if (dma_rd_req_valid && dma_rd_req_ready && cq_wr_valid && cq_wr_ready) idx++;
      cycles++;
      if (cycles > 4000) begin
        $display("%s: timeout, only %0d of %0d steps accepted", name, idx, total);
        abort_run();
      end
    end
    if (dma_xfers != total || cq_xfers != total) begin
      $display("%s: %0d request and %0d queue transfers for %0d steps", name, dma_xfers,
               cq_xfers, total);
      abort_run();
    end
    // drain, nothing may be issued before egress is done
    repeat (6) begin
      @(posedge nvdla_core_clk);
      dma_rd_req_ready <= 1'b1;
      cq_wr_ready <= 1'b1;
      // held enable restarts the walk if drain is skipped
      reg2dp_op_en <= 1'b1;
      @(negedge nvdla_core_clk);
      if (dma_rd_req_valid || cq_wr_valid) begin
        $display("%s: valid raised before the egress done pulse", name);
        abort_run();
      end
    end
    @(posedge nvdla_core_clk);
    eg2ig_done <= 1'b1;
    reg2dp_op_en <= 1'b0;
    @(posedge nvdla_core_clk);
    eg2ig_done <= 1'b0;
    @(negedge nvdla_core_clk);
    // even layers report into d0, odd ones into d1
    perf_seen[layer_cnt % 2] = stalls;
    check_perf(name, perf_seen[0], dp2reg_d0_perf_read_stall);
    check_perf(name, perf_seen[1], dp2reg_d1_perf_read_stall);
    layer_cnt++;
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================
  task automatic test_one_group();
    // 6 atoms wide, one channel group, one request per line
    run_layer("one_group", 13'd31, 13'd5, 13'd3, 64'h0000_0001_0000_1000,
              32'h0000_0400, 32'h0001_0000, 1'b0, 1'b1);
  endtask

  task automatic test_multi_group();
    // 3 channel groups, 21 atoms so sizes 7, 7, 4
    run_layer("multi_group", 13'd95, 13'd20, 13'd2, 64'h0000_0012_8000_0000,
              32'h0000_2000, 32'h0010_0000, 1'b0, 1'b1);
  endtask

  task automatic test_back_pressure();
    run_layer("back_pressure", 13'd63, 13'd10, 13'd2, 64'h0000_0000_4000_0040,
              32'h0000_0800, 32'h0002_0000, 1'b1, 1'b1);
  endtask

  task automatic test_second_layer();
    // new base right after the previous layer, d0 must hold its count
    run_layer("second_layer", 13'd40, 13'd17, 13'd1, 64'h0000_00ff_0000_0000,
              32'h0000_1000, 32'h0004_0000, 1'b1, 1'b1);
  endtask

  task automatic test_stall_disabled();
    run_layer("stall_disabled", 13'd0, 13'd3, 13'd3, 64'h0000_0003_0000_0200,
              32'h0000_0100, 32'h0000_8000, 1'b1, 1'b0);
  endtask

  initial begin
    nvdla_core_rstn <= 1'b0;
    reg2dp_op_en <= 1'b0;
    reg2dp_dma_en <= 1'b0;
    reg2dp_channel <= '0;
    reg2dp_width <= '0;
    reg2dp_height <= '0;
    reg2dp_src_base_addr_high <= '0;
    reg2dp_src_base_addr_low <= '0;
    reg2dp_src_line_stride <= '0;
    reg2dp_src_surface_stride <= '0;
    dma_rd_req_ready <= 1'b0;
    cq_wr_ready <= 1'b0;
    eg2ig_done <= 1'b0;
    rng_state = 32'h900b_d328;
    layer_cnt = 0;
    perf_seen[0] = '0;
    perf_seen[1] = '0;
    repeat (4) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    @(negedge nvdla_core_clk);
    if (dma_rd_req_valid || cq_wr_valid) begin
      $display("reset: valid high while idle after reset");
      abort_run();
    end
    check_perf("reset", '0, dp2reg_d0_perf_read_stall);
    check_perf("reset", '0, dp2reg_d1_perf_read_stall);
    test_one_group();
    test_multi_group();
    test_back_pressure();
    test_second_layer();
    test_stall_disabled();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hw/cdp_rdma_pkg.sv
hw/rdma_layer_ctrl.sv
hw/rdma_cube_walker.sv
hw/rdma_addr_gen.sv
hw/rdma_stall_perf.sv
hw/cdp_rdma_ig.sv
sim/tb_cdp_rdma_ig.sv

// File: Makefile
# Verilator build and run of the read DMA ingress testbench
TOP := tb_cdp_rdma_ig
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ)/V$(TOP)

$(OBJ)/V$(TOP): files.f $(wildcard hw/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f \
		-Mdir $(OBJ) -o V$(TOP)

# exit status of the simulation binary is the test result
run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
